// ==== files.f ====
verilog/sdc_pkg.sv
verilog/sdc_ctrl_if.sv
verilog/sdc_regs.sv
verilog/sdc_shifter.sv
verilog/sdc_crc.sv
verilog/sdc_top.sv
dv/sdc_sva.sv
dv/sdc_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := sdc_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
RUN_FLAGS := +verilator+error+limit+100
PASS_MSG  := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/sdc_tb.sv ====
// Directed testbench for the SD card SPI host with a byte-wide card model.
// Every transfer is a full 8 bits, which keeps the card model's bit index aligned.

`timescale 1ns/10ps

module sdc_tb import sdc_pkg::*; ();

  logic        clk;
  logic        rst;
  logic        stb;
  logic        we;
  logic [3:2]  addr;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        ack;
  logic        ss_n;
  logic        sclk;
  logic        mosi;
  logic        miso;
  logic        wp;

  logic [7:0]  card_byte;             // Byte the card returns.
  logic [7:0]  card_rx = '0;          // Byte the card received.
  logic [2:0]  card_bit = '0;
  logic        sclk_prev = 1'b0;
  logic [31:0] rng_state = 32'hec7a_e0a8;
  int          errors;
  int          timeouts;

  sdc_top sdc_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Card side of SPI mode 0, updated on the falling clk edge.
  assign miso = ss_n ? 1'b1 : card_byte[3'd7 - card_bit];

  always @(negedge clk) begin
    if (sclk && !sclk_prev) begin
      card_rx <= {card_rx[6:0], mosi};
    end
    if (!sclk && sclk_prev) begin
      card_bit <= card_bit + 3'd1;
    end
    sclk_prev <= sclk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [6:0] crc7_byte(input logic [6:0] crc, input logic [7:0] b);
    logic [6:0] c;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      c = {c[5:0], 1'b0} ^ ((c[6] ^ b[i]) ? 7'h09 : 7'h00); // x^7+x^3+1.
    end
    return c;
  endfunction

  function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] c;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      c = {c[14:0], 1'b0} ^ ((c[15] ^ b[i]) ? 16'h1021 : 16'h0000); // x^16+x^12+x^5+1.
    end
    return c;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift(rng_state);
    r = rng_state;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERROR at %t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic bus_write(input logic [1:0] a, input logic [31:0] d);
    stb     = 1'b1;
    we      = 1'b1;
    addr    = a;
    data_in = d;
    @(negedge clk);
    stb = 1'b0;
    we  = 1'b0;
  endtask

  // Read data is combinational, so it is taken just after the inputs settle.
  task automatic bus_read(input logic [1:0] a, output logic [31:0] d);
    stb  = 1'b1;
    we   = 1'b0;
    addr = a;
    #1;
    d = data_out;
    check_value("ack", 32'h1, {31'h0, ack});
    @(negedge clk);
    stb = 1'b0;
  endtask

  task automatic wait_ready(output int clocks);
    logic [31:0] status;
    int          polls;
    polls  = 0;
    status = '0;
    while (!status[0] && polls < 2000) begin
      bus_read(reg_ctrl, status);
      polls++;
    end
    clocks = polls - 1; // The first poll comes before the first edge after the write.
    assert (status[0]) else begin
      $display("Timeout at %t: ready flag still low after %0d polls", $time, polls);
      timeouts++;
    end
  endtask

  task automatic transfer(input logic [7:0] tx, input logic [7:0] card, output int clocks);
    logic [31:0] rd;
    card_byte = card;
    bus_write(reg_data, {24'h0, tx});
    wait_ready(clocks);
    bus_read(reg_data, rd);
    check_value("card mosi byte", {24'h0, tx}, {24'h0, card_rx});
    check_value("rx_byte", {24'h0, card}, rd);
    bus_read(reg_ctrl, rd);
    check_value("ready after data read", 32'h0, {31'h0, rd[0]});
  endtask

  task automatic reset_values();
    logic [31:0] rd;
    check_value("ss_n", 32'h1, {31'h0, ss_n});
    check_value("sclk", 32'h0, {31'h0, sclk});
    check_value("mosi", 32'h1, {31'h0, mosi});
    bus_read(reg_ctrl, rd);
    check_value("status", 32'h0, rd);
    wp = 1'b1;
    bus_read(reg_ctrl, rd);
    check_value("status", 32'h2, rd);
    wp = 1'b0;
  endtask

  task automatic exchange(input logic fast, input int count);
    logic [31:0] r;
    int          clocks;
    int          min_clocks;
    min_clocks = fast ? 17 : 1088; // 17 phases of 1 or 64 clocks.
    bus_write(reg_ctrl, {30'h0, fast, 1'b1});
    check_value("ss_n", 32'h0, {31'h0, ss_n});
    for (int n = 0; n < count; n++) begin
      next_rand(r);
      transfer(r[7:0], r[15:8], clocks);
      assert (clocks >= min_clocks) else begin
        $display("ERROR at %t: transfer clocks expected >= %0d, got %0d",
                 $time, min_clocks, clocks);
        errors++;
      end
    end
  endtask

  task automatic crc7_command(input logic [39:0] cmd, output logic [31:0] rd);
    logic [6:0] ref_crc;
    int         clocks;
    ref_crc = '0;
    bus_write(reg_crc7, 32'h0);
    for (int n = 4; n >= 0; n--) begin
      ref_crc = crc7_byte(ref_crc, cmd[n*8 +: 8]);
      transfer(cmd[n*8 +: 8], 8'hff, clocks);
    end
    bus_read(reg_crc7, rd);
    check_value("crc7", {24'h0, ref_crc, 1'b0}, rd);
  endtask

  task automatic crc16_stream(input logic from_miso);
    logic [31:0] r;
    logic [31:0] rd;
    logic [15:0] ref_crc;
    int          clocks;
    ref_crc = '0;
    bus_write(reg_ctrl, {29'h0, from_miso, 2'b11});
    bus_write(reg_crc16, 32'h0);
    for (int n = 0; n < 6; n++) begin
      next_rand(r);
      ref_crc = crc16_byte(ref_crc, from_miso ? r[15:8] : r[7:0]);
      transfer(r[7:0], r[15:8], clocks);
    end
    bus_read(reg_crc16, rd);
    check_value(from_miso ? "crc16 over miso" : "crc16 over mosi", {16'h0, ref_crc}, rd);
  endtask

  task automatic seed_readback();
    logic [31:0] r;
    logic [31:0] rd;
    next_rand(r);
    bus_write(reg_crc7, r);
    bus_write(reg_crc16, r);
    bus_read(reg_crc7, rd);
    check_value("crc7 seed", {24'h0, r[7:0]}, rd);
    bus_read(reg_crc16, rd);
    check_value("crc16 seed", {16'h0, r[15:0]}, rd);
    bus_write(reg_ctrl, 32'h2);
    check_value("ss_n", 32'h1, {31'h0, ss_n});
  endtask

  initial begin
    logic [31:0] rd;
    $timeformat(-9, 1, " ns", 0);
    errors    = 0;
    timeouts  = 0;
    rst       = 1'b1;
    stb       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    data_in   = '0;
    wp        = 1'b0;
    card_byte = 8'hff;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    reset_values();
    exchange(1'b1, 8);
    exchange(1'b0, 2);
    crc7_command(40'h40_0000_0000, rd);
    check_value("crc7 of CMD0", 32'h94, rd);
    crc7_command(40'h48_0000_01aa, rd);
    crc16_stream(1'b1);
    crc16_stream(1'b0);
    seed_readback();
    $display("Errors: %0d, timeouts: %0d, assertion failures: %0d",
             errors, timeouts, sdc_top_i.sva_i.fail_count);
    if (errors == 0 && timeouts == 0 && sdc_top_i.sva_i.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/sdc_sva.sv ====
// Bound checks on the SD card SPI host top level.
// The shifter state and interface pulses reach it through the bind connections.

`timescale 1ns/10ps

module sdc_sva import sdc_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       stb,
  input logic       ack,
  input logic       sclk,
  input logic       mosi,
  input logic       start,
  input logic       done,
  input sdc_state_e state
);

  int unsigned fail_count = 0;

  idle_sclk_low: assert property (@(posedge clk) disable iff (rst)
    state == st_idle |-> !sclk) else begin
    fail_count++;
    $error("sclk high while the shifter is idle");
  end

  ack_follows_stb: assert property (@(posedge clk) ack == stb) else begin
    fail_count++;
    $error("ack differs from stb");
  end

  mosi_high_after_rst: assert property (@(posedge clk) rst |=> mosi) else begin
    fail_count++;
    $error("mosi low one cycle after reset");
  end

  no_pulse_in_rst: assert property (@(negedge clk) rst |-> !(start || done)) else begin
    fail_count++;
    $error("start or done pulse during reset");
  end

endmodule

bind sdc_top sdc_sva sva_i (
  .clk   (clk),
  .rst   (rst),
  .stb   (stb),
  .ack   (ack),
  .sclk  (sclk),
  .mosi  (mosi),
  .start (ctrl_if.start),
  .done  (ctrl_if.done),
  .state (shifter_i.state)
);

// ==== verilog/sdc_top.sv ====
// SD card host in SPI mode with a four word register bus.
// ack follows stb in the same cycle; software polls ready before each data write.

`timescale 1ns/10ps

module sdc_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        stb,
  input  logic        we,
  input  logic [3:2]  addr,
  input  logic [31:0] data_in,
  output logic [31:0] data_out,
  output logic        ack,
  output logic        ss_n,
  output logic        sclk,
  output logic        mosi,
  input  logic        miso,
  input  logic        wp
);

  sdc_ctrl_if ctrl_if ();

  assign ack = stb; // No wait states.

  sdc_regs regs_i (
    .clk      (clk),
    .rst      (rst),
    .stb      (stb),
    .we       (we),
    .addr     (addr),
    .data_in  (data_in),
    .data_out (data_out),
    .wp       (wp),
    .ss_n     (ss_n),
    .ctrl     (ctrl_if.regs)
  );

  sdc_shifter shifter_i (
    .clk  (clk),
    .rst  (rst),
    .sclk (sclk),
    .mosi (mosi),
    .miso (miso),
    .ctrl (ctrl_if.shifter)
  );

  sdc_crc crc_i (
    .clk  (clk),
    .rst  (rst),
    .ctrl (ctrl_if.crc)
  );

endmodule

// ==== verilog/sdc_crc.sv ====
// CRC7 (x^7+x^3+1) in bits 7:1 and CRC16 (x^16+x^12+x^5+1), one bit per rising SCLK.
// A seed write takes priority over an update in the same cycle.

`timescale 1ns/10ps

module sdc_crc (
  input  logic    clk,
  input  logic    rst,
  sdc_ctrl_if.crc ctrl
);

  logic [7:0]  crc7;
  logic [15:0] crc16;
  logic        fb7;
  logic        fb16;
  logic        crc16_in;

  assign crc16_in = ctrl.crc_from_miso ? ctrl.miso_bit : ctrl.mosi_bit;
  assign fb7      = crc7[7] ^ ctrl.mosi_bit;
  assign fb16     = crc16[15] ^ crc16_in;

  always_ff @(posedge clk) begin
    if (rst) begin
      crc7 <= '0;
    end else if (ctrl.crc7_load) begin
      crc7 <= ctrl.seed[7:0];
    end else if (ctrl.bit_sample) begin
      crc7[7:1] <= {crc7[6:4], crc7[3] ^ fb7, crc7[2:1], fb7}; // Bit 0 is held.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      crc16 <= '0;
    end else if (ctrl.crc16_load) begin
      crc16 <= ctrl.seed;
    end else if (ctrl.bit_sample) begin
      crc16 <= {crc16[14:12], crc16[11] ^ fb16, crc16[10:5],
                crc16[4] ^ fb16, crc16[3:0], fb16};
    end
  end

  assign ctrl.crc7  = crc7;
  assign ctrl.crc16 = crc16;

endmodule

// ==== verilog/sdc_shifter.sv ====
// SPI mode 0 shift engine, MSB first, one byte per start.
// A start while busy reloads the shift register but does not restart the sequence.

`timescale 1ns/10ps

module sdc_shifter import sdc_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  output logic        sclk,
  output logic        mosi,
  input  logic        miso,
  sdc_ctrl_if.shifter ctrl
);

  sdc_state_e            state;
  logic [SDC_WAIT_W-1:0] wtcnt;
  logic [SDC_WAIT_W-1:0] wait_val;
  logic [2:0]            bitcnt;
  logic [8:0]            sreg;
  logic                  phase_end;
  logic                  shift;

  assign wait_val  = ctrl.fast_clock ? SDC_FAST_WAIT : SDC_SLOW_WAIT;
  assign phase_end = (wtcnt == '0);

  assign ctrl.bit_sample = (state == st_low) && phase_end;  // SCLK rises.
  assign shift           = (state == st_high) && phase_end; // SCLK falls.
  assign ctrl.done       = (state == st_done) && phase_end;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_idle;
      wtcnt  <= '0;
      bitcnt <= '0;
      sclk   <= 1'b0;
    end else if (!phase_end) begin
      wtcnt <= wtcnt - 1'b1;
    end else begin
      case (state)
        st_idle: begin
          if (ctrl.start) begin
            state  <= st_low; // Leading low phase sets up the first bit.
            wtcnt  <= wait_val;
            bitcnt <= '0;
          end
        end
        st_low: begin
          sclk  <= 1'b1;
          state <= st_high;
          wtcnt <= wait_val;
        end
        st_high: begin
          sclk   <= 1'b0;
          wtcnt  <= wait_val;
          bitcnt <= bitcnt + 1'b1;
          if (bitcnt == 3'(SDC_BITS - 1)) begin
            state <= st_done;
          end else begin
            state <= st_low;
          end
        end
        st_done: begin
          state <= st_idle;
        end
        default: begin
          sclk  <= 1'b0;
          state <= st_idle;
        end
      endcase
    end
  end

  // Bit 0 catches miso on the rising edge and moves up on the falling edge.
  always_ff @(posedge clk) begin
    if (rst) begin
      sreg <= '1;
    end else if (ctrl.start) begin
      sreg[8:1] <= ctrl.tx_byte;
    end else begin
      if (shift) begin
        sreg[8:1] <= sreg[7:0];
      end
      if (ctrl.bit_sample) begin
        sreg[0] <= miso;
      end
    end
  end

  assign mosi          = sreg[8];
  assign ctrl.mosi_bit = sreg[8];
  assign ctrl.miso_bit = miso;
  assign ctrl.rx_byte  = sreg[8:1];

endmodule

// ==== verilog/sdc_regs.sv ====
// Register block of the SD card SPI host. Zero wait state bus.
// A data write during a running transfer is not guarded against.

`timescale 1ns/10ps

module sdc_regs import sdc_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        stb,
  input  logic        we,
  input  logic [3:2]  addr,
  input  logic [31:0] data_in,
  output logic [31:0] data_out,
  input  logic        wp,
  output logic        ss_n,
  sdc_ctrl_if.regs    ctrl
);

  sdc_reg_e sel;
  logic     wr;
  logic     rd_data;
  logic     ready;
  logic     fast_clock;
  logic     crc_from_miso;

  assign sel     = sdc_reg_e'(addr);
  assign wr      = stb & we;
  assign rd_data = stb & ~we & (sel == reg_data);

  assign ctrl.start         = wr & (sel == reg_data);
  assign ctrl.crc7_load     = wr & (sel == reg_crc7);
  assign ctrl.crc16_load    = wr & (sel == reg_crc16);
  assign ctrl.tx_byte       = data_in[7:0];
  assign ctrl.seed          = data_in[15:0];
  assign ctrl.fast_clock    = fast_clock;
  assign ctrl.crc_from_miso = crc_from_miso;

  always_ff @(posedge clk) begin
    if (rst) begin
      ss_n          <= 1'b1;
      fast_clock    <= 1'b0;
      crc_from_miso <= 1'b0;
    end else if (wr && sel == reg_ctrl) begin
      ss_n          <= ~data_in[0]; // Bit 0 selects the card.
      fast_clock    <= data_in[1];
      crc_from_miso <= data_in[2];
    end
  end

  // done wins over a data read in the same cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      ready <= 1'b0;
    end else if (ctrl.done || rd_data) begin
      ready <= ctrl.done;
    end
  end

  always_comb begin
    data_out = '0;
    case (sel)
      reg_ctrl:  data_out[1:0]  = {wp, ready};
      reg_data:  data_out[7:0]  = ctrl.rx_byte;
      reg_crc7:  data_out[7:0]  = ctrl.crc7;
      reg_crc16: data_out[15:0] = ctrl.crc16;
      default:   data_out       = '0;
    endcase
  end

endmodule

// ==== verilog/sdc_ctrl_if.sv ====
// Control, transfer and CRC signals between the register block and the engines.
// start, done, bit_sample and the CRC loads are single-cycle pulses.

`timescale 1ns/10ps

interface sdc_ctrl_if;

  logic        start;
  logic [7:0]  tx_byte;
  logic        fast_clock;
  logic        crc_from_miso;
  logic        crc7_load;
  logic        crc16_load;
  logic [15:0] seed;

  logic [7:0]  rx_byte;
  logic        done;
  logic        bit_sample;
  logic        mosi_bit;
  logic        miso_bit;

  logic [7:0]  crc7;
  logic [15:0] crc16;

  modport regs (output start, tx_byte, fast_clock, crc_from_miso, crc7_load, crc16_load, seed,
                input rx_byte, done, crc7, crc16);

  modport shifter (input start, tx_byte, fast_clock,
                   output rx_byte, done, bit_sample, mosi_bit, miso_bit);

  modport crc (input crc7_load, crc16_load, seed, bit_sample, mosi_bit, miso_bit,
               crc_from_miso, output crc7, crc16);

endinterface

// ==== verilog/sdc_pkg.sv ====
// Shared types and constants of the SD card SPI host.
// SCLK rate is clk / (2 * (wait + 1)); the slow rate suits card init at 25 MHz clk.

package sdc_pkg;

  // Register word selected by addr[3:2].
  typedef enum logic [1:0] {
    reg_ctrl  = 2'd0,
    reg_data  = 2'd1,
    reg_crc7  = 2'd2,
    reg_crc16 = 2'd3
  } sdc_reg_e;

  // Shifter phase sequence.
  typedef enum logic [1:0] {
    st_idle,
    st_high, // SCLK high phase.
    st_low,  // SCLK low phase.
    st_done  // Trailing low half period.
  } sdc_state_e;

  localparam int SDC_WAIT_W = 6; // Divider counter width.

  // Divider reload values per SCLK half period.
  localparam logic [SDC_WAIT_W-1:0] SDC_FAST_WAIT = 6'd0;
  localparam logic [SDC_WAIT_W-1:0] SDC_SLOW_WAIT = 6'd63;

  localparam int SDC_BITS = 8; // Bits per transfer.

endpackage
